// File: vlog.f
+incdir+dv
src/video_pkg.sv
src/track_pkg.sv
src/raster_counter.sv
src/frame_diff.sv
src/measure_position.sv
src/centroid_divider.sv
src/position_report.sv
src/motion_tracker_top.sv
dv/motion_tracker_tb.sv

// File: dv/tb_reference.svh
`ifndef TB_REFERENCE_SVH
`define TB_REFERENCE_SVH

// motion flag of one pixel, current frame against the previous one
function automatic bit pixel_moves(input int idx);
	int diff;
	diff = int'(cur_frame[idx]) - int'(prev_frame[idx]);
	if (diff < 0)
		diff = -diff;
	return (diff >= DIFF_THRESH);
endfunction

// expected {x, y} of cur_frame, all ones when there is no object
function automatic logic [21:0] ref_centroid(input bit primed);
	int count;
	int sum_x;
	int sum_y;
	count = 0;
	sum_x = 0;
	sum_y = 0;
	if (primed)
	begin
		for (int yy = 0; yy < FRAME_H; yy++)
		begin
			for (int xx = 0; xx < FRAME_W; xx++)
			begin
				// the last pixel of a frame is never accumulated
				if (!(xx == FRAME_W - 1 && yy == FRAME_H - 1) &&
					pixel_moves(yy * FRAME_W + xx))
				begin
					count++;
					sum_x += xx;
					sum_y += yy;
				end
			end
		end
	end
	if (count < COUNT_THRESH)
		return {11'h7ff, 11'h7ff};
	return {11'(sum_x / count), 11'(sum_y / count)};
endfunction

`endif

// File: dv/motion_tracker_tb.sv
module motion_tracker_tb;

	localparam int FRAME_W        = 16;
	localparam int FRAME_H        = 12;
	localparam int DIFF_THRESH    = 32;
	localparam int COUNT_THRESH   = 4;
	localparam int FRAME_PIX      = FRAME_W * FRAME_H;
	localparam int NUM_FRAMES     = 19;	// partial frame counted as one
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * (FRAME_PIX + 20) + 500;

	logic        clk;
	logic        aresetn;
	logic        enable;
	logic [7:0]  pixel;
	logic        pixel_valid;
	logic [10:0] x_position;
	logic [10:0] y_position;
	logic        req;
	logic        ack;
	logic        overrun;

	integer      seed;
	int          error_count = 0;
	int          check_count = 0;
	int          cycle_count = 0;
	int          ack_delay   = 1;
	bit          ref_primed;
	bit          overrun_ok;
	bit          overrun_reported;
	logic [7:0]  background [FRAME_PIX];
	logic [7:0]  cur_frame [FRAME_PIX];
	logic [7:0]  prev_frame [FRAME_PIX];
	logic [21:0] exp_q [$];
	logic [21:0] exp_entry;
	logic [10:0] held_x;
	logic [10:0] held_y;
	logic        prev_req = 1'b0;
	logic        prev_ack = 1'b0;
	logic        prev_en  = 1'b0;

	`include "tb_reference.svh"

	motion_tracker_top #(
		.FRAME_W      (FRAME_W),
		.FRAME_H      (FRAME_H),
		.DIFF_THRESH  (DIFF_THRESH),
		.COUNT_THRESH (COUNT_THRESH)
	) i_motion_tracker_top (
		.clk         (clk),
		.aresetn     (aresetn),
		.enable      (enable),
		.pixel       (pixel),
		.pixel_valid (pixel_valid),
		.x_position  (x_position),
		.y_position  (y_position),
		.req         (req),
		.ack         (ack),
		.overrun     (overrun)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("CHECK FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual,
				expected);
		end
	endtask

	task automatic report_error(input string msg);
		error_count++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic finish_run();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	endtask

	// bright rectangle over the static background
	task automatic build_frame(input int rx, input int ry, input int rw, input int rh);
		int idx;
		for (int yy = 0; yy < FRAME_H; yy++)
		begin
			for (int xx = 0; xx < FRAME_W; xx++)
			begin
				idx = yy * FRAME_W + xx;
				if (xx >= rx && xx < rx + rw && yy >= ry && yy < ry + rh)
					cur_frame[idx] = 8'd240;
				else
					cur_frame[idx] = background[idx];
			end
		end
	endtask

	task automatic send_pixels(input int npix, input bit gaps);
		for (int i = 0; i < npix; i++)
		begin
			if (gaps && ({$random(seed)} % 16 == 0))
			begin
				@(posedge clk);
				#10;
				pixel_valid = 1'b0;	// idle cycle inside the frame
			end
			@(posedge clk);
			#10;
			pixel       = cur_frame[i];
			pixel_valid = 1'b1;
		end
		@(posedge clk);
		#10;
		pixel_valid = 1'b0;
	endtask

	task automatic run_frame(input int rx, input int ry, input int rw, input int rh,
		input bit gaps, input bit keep);
		logic [21:0] expected;
		build_frame(rx, ry, rw, rh);
		expected = ref_centroid(ref_primed);
		send_pixels(FRAME_PIX, gaps);
		if (keep)
			exp_q.push_back(expected);	// otherwise the result is lost to overrun
		prev_frame = cur_frame;
		ref_primed = 1'b1;
	endtask

	task automatic wait_handshake_idle(input int max_cycles);
		int n;
		n = 0;
		while ((exp_q.size() != 0 || req || ack) && n < max_cycles)
		begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0)
		begin
			report_error($sformatf("missing req, %0d results were never offered",
				exp_q.size()));
			exp_q.delete();
		end
		else if (req || ack)
			report_error("handshake did not return to idle");
	endtask

	// consumer side of the four-phase port
	initial
	begin
		int delay;
		ack = 1'b0;
		forever
		begin
			@(negedge clk);
			if (req)
			begin
				delay = ack_delay;
				repeat (delay) @(posedge clk);
				@(posedge clk);
				#10;
				ack = 1'b1;
				@(negedge clk);
				while (req)
					@(negedge clk);
				@(posedge clk);
				#10;
				ack = 1'b0;
			end
		end
	end

	// compare offered results with the expected queue
	always @(negedge clk)
	begin
		if (aresetn)
		begin
			if (req && !prev_req)
			begin
				if (exp_q.size() == 0)
					report_error("unexpected req with no result pending");
				else
				begin
					exp_entry = exp_q.pop_front();
					check_value("x_position", x_position, exp_entry[21:11]);
					check_value("y_position", y_position, exp_entry[10:0]);
				end
				held_x = x_position;
				held_y = y_position;
			end
			else if (req)
			begin
				check_value("x_position (held)", x_position, held_x);
				check_value("y_position (held)", y_position, held_y);
			end
			else if (prev_req && !prev_ack && prev_en)
				report_error("req dropped before ack was seen");
			if (overrun && !overrun_ok && !overrun_reported)
			begin
				report_error("unexpected overrun");
				overrun_reported = 1'b1;
			end
		end
		prev_req = req;
		prev_ack = ack;
		prev_en  = enable;
	end

	initial
	begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		report_error($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
		finish_run();
	end

	initial
	begin
		seed             = 65;
		aresetn          = 1'b0;
		enable           = 1'b0;
		pixel            = '0;
		pixel_valid      = 1'b0;
		ref_primed       = 1'b0;
		overrun_ok       = 1'b0;
		overrun_reported = 1'b0;
		for (int i = 0; i < FRAME_PIX; i++)
			background[i] = 8'({$random(seed)} % 128);
		repeat (2) @(posedge clk);
		#10;
		aresetn = 1'b1;
		enable  = 1'b1;

		run_frame(2, 2, 4, 3, 1'b0, 1'b1);	// store not primed yet
		for (int f = 0; f < 5; f++)
			run_frame({$random(seed)} % 12, {$random(seed)} % 9, 4, 3, 1'b1, 1'b1);

		// single pixel step, then a repeated frame
		run_frame(5, 5, 1, 1, 1'b0, 1'b1);
		run_frame(6, 5, 1, 1, 1'b0, 1'b1);
		run_frame(6, 5, 1, 1, 1'b0, 1'b1);

		wait_handshake_idle(100);
		ack_delay = 40;
		run_frame(3, 4, 4, 3, 1'b0, 1'b1);
		run_frame(8, 6, 4, 3, 1'b0, 1'b1);

		// ack held past the next frame end
		wait_handshake_idle(100);
		ack_delay  = 250;
		overrun_ok = 1'b1;
		run_frame(1, 1, 5, 4, 1'b0, 1'b1);
		run_frame(9, 6, 5, 4, 1'b0, 1'b0);
		ack_delay = 2;
		run_frame(4, 7, 3, 3, 1'b0, 1'b1);
		check_value("overrun", overrun, 1);

		// drop enable while a result is still offered
		wait_handshake_idle(100);
		ack_delay = 150;
		run_frame(10, 2, 4, 4, 1'b0, 1'b1);
		build_frame(0, 0, 4, 4);
		send_pixels(64, 1'b0);
		@(posedge clk);
		#10;
		enable = 1'b0;
		repeat (2) @(posedge clk);
		#10;
		check_value("req", req, 0);
		check_value("overrun", overrun, 0);
		ref_primed = 1'b0;
		overrun_ok = 1'b0;
		enable     = 1'b1;
		ack_delay  = 2;
		run_frame(2, 8, 4, 3, 1'b0, 1'b1);
		run_frame(7, 3, 4, 3, 1'b0, 1'b1);
		run_frame(11, 5, 4, 3, 1'b0, 1'b1);

		wait_handshake_idle(100);
		finish_run();
	end

endmodule

// File: src/motion_tracker_top.sv
module motion_tracker_top #(
	parameter int FRAME_W      = 16,
	parameter int FRAME_H      = 12,
	parameter int DIFF_THRESH  = 32,
	parameter int COUNT_THRESH = 4
) (
	input  logic                 clk,
	input  logic                 aresetn,
	input  logic                 enable,
	input  video_pkg::pixel_t    pixel,
	input  logic                 pixel_valid,
	output track_pkg::position_t x_position,
	output track_pkg::position_t y_position,
	output logic                 req,
	input  logic                 ack,
	output logic                 overrun
);
	import video_pkg::*;
	import track_pkg::*;

	pixel_t     rc_pix;
	coord_t     rc_x;
	coord_t     rc_y;
	logic       rc_valid;
	logic       rc_frame_end;
	coord_t     fd_x;
	coord_t     fd_y;
	logic       fd_moving;
	logic       fd_valid;
	logic       fd_frame_end;
	logic       mp_start;
	coord_sum_t mp_x_sum;
	coord_sum_t mp_y_sum;
	count_t     mp_count;
	logic       mp_result_valid;
	position_t  mp_x_position;
	position_t  mp_y_position;
	position_t  dv_x_quot;
	position_t  dv_y_quot;
	logic       dv_done;

	raster_counter #(
		.FRAME_W (FRAME_W),
		.FRAME_H (FRAME_H)
	) i_raster_counter (
		.clk         (clk),
		.aresetn     (aresetn),
		.enable      (enable),
		.pixel       (pixel),
		.pixel_valid (pixel_valid),
		.pix_out     (rc_pix),
		.x           (rc_x),
		.y           (rc_y),
		.valid       (rc_valid),
		.frame_end   (rc_frame_end)
	);

	frame_diff #(
		.FRAME_W     (FRAME_W),
		.FRAME_H     (FRAME_H),
		.DIFF_THRESH (DIFF_THRESH)
	) i_frame_diff (
		.clk          (clk),
		.aresetn      (aresetn),
		.enable       (enable),
		.pix_in       (rc_pix),
		.x_in         (rc_x),
		.y_in         (rc_y),
		.valid_in     (rc_valid),
		.frame_end_in (rc_frame_end),
		.x            (fd_x),
		.y            (fd_y),
		.moving       (fd_moving),
		.valid        (fd_valid),
		.frame_end    (fd_frame_end)
	);

	measure_position #(
		.COUNT_THRESH (COUNT_THRESH)
	) i_measure_position (
		.clk          (clk),
		.aresetn      (aresetn),
		.enable       (enable),
		.x            (fd_x),
		.y            (fd_y),
		.moving       (fd_moving),
		.valid        (fd_valid),
		.frame_end    (fd_frame_end),
		.x_quot       (dv_x_quot),
		.y_quot       (dv_y_quot),
		.done         (dv_done),
		.start        (mp_start),
		.x_sum        (mp_x_sum),
		.y_sum        (mp_y_sum),
		.count        (mp_count),
		.result_valid (mp_result_valid),
		.x_position   (mp_x_position),
		.y_position   (mp_y_position)
	);

	centroid_divider i_centroid_divider (
		.clk     (clk),
		.aresetn (aresetn),
		.enable  (enable),
		.start   (mp_start),
		.x_sum   (mp_x_sum),
		.y_sum   (mp_y_sum),
		.count   (mp_count),
		.x_quot  (dv_x_quot),
		.y_quot  (dv_y_quot),
		.done    (dv_done)
	);

	position_report i_position_report (
		.clk           (clk),
		.aresetn       (aresetn),
		.enable        (enable),
		.result_valid  (mp_result_valid),
		.x_position_in (mp_x_position),
		.y_position_in (mp_y_position),
		.ack           (ack),
		.x_position    (x_position),
		.y_position    (y_position),
		.req           (req),
		.overrun       (overrun)
	);

endmodule

// File: src/position_report.sv
module position_report (
	input  logic                 clk,
	input  logic                 aresetn,
	input  logic                 enable,
	input  logic                 result_valid,
	input  track_pkg::position_t x_position_in,
	input  track_pkg::position_t y_position_in,
	input  logic                 ack,
	output track_pkg::position_t x_position,
	output track_pkg::position_t y_position,
	output logic                 req,
	output logic                 overrun
);
	import track_pkg::*;

	report_state_t state;
	logic          accept;

	assign accept = result_valid && (state == rep_empty);
	assign req    = (state == rep_offer);

	always_ff @(posedge clk or negedge aresetn)
	begin
		if (!aresetn)
		begin
			state   <= rep_empty;
			overrun <= 1'b0;
		end
		else if (!enable)
		begin
			state   <= rep_empty;	// pending result is dropped
			overrun <= 1'b0;
		end
		else
		begin
			if (result_valid && state != rep_empty)
				overrun <= 1'b1;	// sticky, new result lost
			case (state)
				rep_empty:
				begin
					if (result_valid)
						state <= rep_offer;
				end
				rep_offer:
				begin
					if (ack)
						state <= rep_wait_release;
				end
				rep_wait_release:
				begin
					if (!ack)
						state <= rep_empty;
				end
				default:
					state <= rep_empty;
			endcase
		end
	end

	// held from accept until the handshake completes
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			x_position <= x_position_in;
			y_position <= y_position_in;
		end
	end

endmodule

// File: src/centroid_divider.sv
module centroid_divider (
	input  logic                  clk,
	input  logic                  aresetn,
	input  logic                  enable,
	input  logic                  start,
	input  track_pkg::coord_sum_t x_sum,
	input  track_pkg::coord_sum_t y_sum,
	input  track_pkg::count_t     count,
	output track_pkg::position_t  x_quot,
	output track_pkg::position_t  y_quot,
	output logic                  done
);
	import track_pkg::*;

	div_state_t       state;
	logic [3:0]       steps_left;
	count_t           divisor;
	count_t           x_rem;
	count_t           y_rem;
	position_t        x_work;	// dividend bits shift out, quotient bits shift in
	position_t        y_work;
	count_t           div_in;
	count_t           x_rem_in;
	count_t           y_rem_in;
	position_t        x_low_in;
	position_t        y_low_in;
	logic [COUNT_W:0] x_step;
	logic [COUNT_W:0] y_step;
	logic             load;
	logic             step_en;

	// one restoring step: returns {new remainder, quotient bit}
	function automatic logic [COUNT_W:0] div_step(input count_t rem, input logic bit_in,
		input count_t dvs);
		logic [COUNT_W:0] trial;
		logic [COUNT_W:0] diff;
		trial = {rem, bit_in};
		diff  = trial - {1'b0, dvs};
		if (trial >= {1'b0, dvs})
			div_step = {diff[COUNT_W-1:0], 1'b1};
		else
			div_step = {trial[COUNT_W-1:0], 1'b0};
	endfunction

	assign load    = enable && (state == div_idle) && start;
	assign step_en = load || (enable && state == div_run);

	// the quotient fits in POS_W bits, so the upper sum bits seed the remainder
	always_comb
	begin
		if (state == div_idle)
		begin
			div_in   = count;
			x_rem_in = count_t'(x_sum[SUM_W-1:POS_W]);
			y_rem_in = count_t'(y_sum[SUM_W-1:POS_W]);
			x_low_in = x_sum[POS_W-1:0];
			y_low_in = y_sum[POS_W-1:0];
		end
		else
		begin
			div_in   = divisor;
			x_rem_in = x_rem;
			y_rem_in = y_rem;
			x_low_in = x_work;
			y_low_in = y_work;
		end
		x_step = div_step(x_rem_in, x_low_in[POS_W-1], div_in);
		y_step = div_step(y_rem_in, y_low_in[POS_W-1], div_in);
	end

	always_ff @(posedge clk or negedge aresetn)
	begin
		if (!aresetn)
		begin
			state      <= div_idle;
			steps_left <= '0;
		end
		else if (!enable)
			state <= div_idle;	// abort any division in flight
		else
		begin
			case (state)
				div_idle:
				begin
					if (start)
					begin
						state      <= div_run;
						steps_left <= 4'(POS_W - 1);	// first bit done at load
					end
				end
				div_run:
				begin
					steps_left <= steps_left - 1'b1;
					if (steps_left == 4'd1)
						state <= div_done;
				end
				default:
					state <= div_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
			divisor <= count;
		if (step_en)
		begin
			x_rem  <= x_step[COUNT_W:1];
			y_rem  <= y_step[COUNT_W:1];
			x_work <= {x_low_in[POS_W-2:0], x_step[0]};
			y_work <= {y_low_in[POS_W-2:0], y_step[0]};
		end
	end

	assign x_quot = x_work;
	assign y_quot = y_work;
	assign done   = (state == div_done);

endmodule

// File: src/measure_position.sv
module measure_position #(
	parameter int COUNT_THRESH = 4
) (
	input  logic                   clk,
	input  logic                   aresetn,
	input  logic                   enable,
	input  video_pkg::coord_t      x,
	input  video_pkg::coord_t      y,
	input  logic                   moving,
	input  logic                   valid,
	input  logic                   frame_end,
	input  track_pkg::position_t   x_quot,
	input  track_pkg::position_t   y_quot,
	input  logic                   done,
	output logic                   start,
	output track_pkg::coord_sum_t  x_sum,
	output track_pkg::coord_sum_t  y_sum,
	output track_pkg::count_t      count,
	output logic                   result_valid,
	output track_pkg::position_t   x_position,
	output track_pkg::position_t   y_position
);
	import track_pkg::*;

	count_t     acc_count;
	coord_sum_t acc_x;
	coord_sum_t acc_y;
	logic       frame_hit;
	logic       take_pixel;
	logic       too_few;

	assign frame_hit  = valid && frame_end;
	assign take_pixel = valid && moving && !frame_end;	// frame-end pixel never counted
	assign too_few    = (acc_count < count_t'(COUNT_THRESH));

	always_ff @(posedge clk or negedge aresetn)
	begin
		if (!aresetn)
		begin
			acc_count <= '0;
			acc_x     <= '0;
			acc_y     <= '0;
		end
		else if (!enable || frame_hit)
		begin
			acc_count <= '0;
			acc_x     <= '0;
			acc_y     <= '0;
		end
		else if (take_pixel)
		begin
			acc_count <= acc_count + 1'b1;
			acc_x     <= acc_x + coord_sum_t'(x);
			acc_y     <= acc_y + coord_sum_t'(y);
		end
	end

	// totals stay put for the divider until the next frame end
	always_ff @(posedge clk)
	begin
		if (frame_hit)
		begin
			x_sum <= acc_x;
			y_sum <= acc_y;
			count <= acc_count;
		end
	end

	always_ff @(posedge clk or negedge aresetn)
	begin
		if (!aresetn)
		begin
			start        <= 1'b0;
			result_valid <= 1'b0;
		end
		else
		begin
			start        <= enable && frame_hit && !too_few;
			result_valid <= enable && ((frame_hit && too_few) || done);
		end
	end

	always_ff @(posedge clk)
	begin
		if (frame_hit && too_few)
		begin
			x_position <= POS_NONE;
			y_position <= POS_NONE;
		end
		else if (done)
		begin
			x_position <= x_quot;
			y_position <= y_quot;
		end
	end

endmodule

// File: src/frame_diff.sv
module frame_diff #(
	parameter int FRAME_W     = 16,
	parameter int FRAME_H     = 12,
	parameter int DIFF_THRESH = 32
) (
	input  logic              clk,
	input  logic              aresetn,
	input  logic              enable,
	input  video_pkg::pixel_t pix_in,
	input  video_pkg::coord_t x_in,
	input  video_pkg::coord_t y_in,
	input  logic              valid_in,
	input  logic              frame_end_in,
	output video_pkg::coord_t x,
	output video_pkg::coord_t y,
	output logic              moving,
	output logic              valid,
	output logic              frame_end
);
	import video_pkg::*;

	localparam int DEPTH  = FRAME_W * FRAME_H;
	localparam int ADDR_W = $clog2(DEPTH);

	pixel_t            store [DEPTH];	// previous frame, one entry per position
	logic [ADDR_W-1:0] addr;
	pixel_t            old_pix;
	pixel_t            abs_diff;
	logic              primed;
	logic              over_thresh;

	assign addr     = ADDR_W'(y_in * FRAME_W + x_in);
	assign old_pix  = store[addr];
	assign abs_diff = (pix_in >= old_pix) ? pix_in - old_pix : old_pix - pix_in;

	// no previous frame to compare against until the store is primed
	assign over_thresh = primed && (abs_diff >= pixel_t'(DIFF_THRESH));

	always_ff @(posedge clk)
	begin
		if (valid_in)
			store[addr] <= pix_in;	// old value already read above
	end

	always_ff @(posedge clk or negedge aresetn)
	begin
		if (!aresetn)
			primed <= 1'b0;
		else if (!enable)
			primed <= 1'b0;
		else if (valid_in && frame_end_in)
			primed <= 1'b1;
	end

	always_ff @(posedge clk or negedge aresetn)
	begin
		if (!aresetn)
		begin
			valid     <= 1'b0;
			frame_end <= 1'b0;
			moving    <= 1'b0;
		end
		else
		begin
			valid     <= enable && valid_in;
			frame_end <= enable && valid_in && frame_end_in;
			moving    <= enable && valid_in && over_thresh;
		end
	end

	always_ff @(posedge clk)
	begin
		if (valid_in)
		begin
			x <= x_in;
			y <= y_in;
		end
	end

endmodule

// File: src/raster_counter.sv
module raster_counter #(
	parameter int FRAME_W = 16,
	parameter int FRAME_H = 12
) (
	input  logic              clk,
	input  logic              aresetn,
	input  logic              enable,
	input  video_pkg::pixel_t pixel,
	input  logic              pixel_valid,
	output video_pkg::pixel_t pix_out,
	output video_pkg::coord_t x,
	output video_pkg::coord_t y,
	output logic              valid,
	output logic              frame_end
);
	import video_pkg::*;

	coord_t cnt_x;
	coord_t cnt_y;
	logic   last_col;
	logic   last_row;

	assign last_col = (cnt_x == coord_t'(FRAME_W - 1));
	assign last_row = (cnt_y == coord_t'(FRAME_H - 1));

	always_ff @(posedge clk or negedge aresetn)
	begin
		if (!aresetn)
		begin
			cnt_x <= '0;
			cnt_y <= '0;
		end
		else if (!enable)
		begin
			cnt_x <= '0;	// next enabled pixel starts a new frame
			cnt_y <= '0;
		end
		else if (pixel_valid)
		begin
			if (last_col)
			begin
				cnt_x <= '0;
				cnt_y <= last_row ? '0 : cnt_y + 1'b1;
			end
			else
				cnt_x <= cnt_x + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge aresetn)
	begin
		if (!aresetn)
		begin
			valid     <= 1'b0;
			frame_end <= 1'b0;
		end
		else
		begin
			valid     <= enable && pixel_valid;
			frame_end <= enable && pixel_valid && last_col && last_row;
		end
	end

	always_ff @(posedge clk)
	begin
		if (pixel_valid)
		begin
			pix_out <= pixel;
			x       <= cnt_x;
			y       <= cnt_y;
		end
	end

endmodule

// File: src/track_pkg.sv
package track_pkg;

	localparam int COUNT_W = 19;
	localparam int SUM_W   = 27;
	localparam int POS_W   = 11;

	typedef logic [COUNT_W-1:0] count_t;	// moving pixels per frame
	typedef logic [SUM_W-1:0]   coord_sum_t;
	typedef logic [POS_W-1:0]   position_t;

	localparam position_t POS_NONE = '1;	// no object found

	typedef enum logic [1:0] {
		div_idle,
		div_run,
		div_done
	} div_state_t;

	typedef enum logic [1:0] {
		rep_empty,
		rep_offer,
		rep_wait_release
	} report_state_t;

endpackage

// File: src/video_pkg.sv
package video_pkg;

	localparam int PIXEL_W = 8;
	localparam int COORD_W = 11;

	// grayscale luma sample
	typedef logic [PIXEL_W-1:0] pixel_t;

	// x or y position inside the frame
	typedef logic [COORD_W-1:0] coord_t;

endpackage
